//--- Makefile
# Verilator build and run of the memory subsystem testbench

VERILATOR ?= verilator
TOP       := tb_mem_subsys
FILELIST  := compile.f
FLAGS     := --binary --timing -j 0
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(wildcard hdl/*.sv) $(wildcard tb/*.sv) $(wildcard tb/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# a $fatal in the testbench gives a nonzero exit status
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

//--- compile.f
+incdir+tb
hdl/memctrl_pkg.sv
hdl/mem_addr_sel.sv
hdl/int_vector_regs.sv
hdl/mem_byte_seq.sv
hdl/sys_ram.sv
hdl/mem_subsys_top.sv
tb/tb_mem_subsys.sv

//--- hdl/int_vector_regs.sv
// programmable interrupt vector registers, written by a config strobe, priority-picked per request
`timescale 1ns/10ps
`default_nettype none

module int_vector_regs import memctrl_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    cfg_we,      // write strobe, completes on this edge
    input  logic    [1:0] cfg_sel, // 0 irq, 1 firq, 2 nmi, 3 rst
    input  addr_t   cfg_wdata,
    input  intvec_t req_intvec,  // pending interrupt bits
    output addr_t   vec_addr
);

    addr_t vec_q [4];  // indexed in intvec bit order

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vec_q[0] <= vec_irq_rst;
            vec_q[1] <= vec_firq_rst;
            vec_q[2] <= vec_nmi_rst;
            vec_q[3] <= vec_rst_rst;
        end else if (cfg_we) begin
            vec_q[cfg_sel] <= cfg_wdata; // software reprogram
        end
    end

    // rst beats nmi, nmi beats firq, firq beats irq
    always_comb begin
        if (req_intvec[3]) begin
            vec_addr = vec_q[3];
        end else if (req_intvec[2]) begin
            vec_addr = vec_q[2];
        end else if (req_intvec[1]) begin
            vec_addr = vec_q[1];
        end else if (req_intvec[0]) begin
            vec_addr = vec_q[0];
        end else begin
            // nothing pending, fall back to the reset vector
            vec_addr = vec_q[3];
        end
    end

endmodule

`default_nettype wire

//--- hdl/mem_addr_sel.sv
// effective address mux for one memory request, picks pc, x, y, stack, index or vector address
`timescale 1ns/10ps
`default_nettype none

module mem_addr_sel import memctrl_pkg::*; (
    input  addr_src_t req_src,   // address source of the pending request
    input  logic      req_wide,  // word access, sets the push decrement
    input  addr_t     pc,
    input  addr_t     regs_x,
    input  addr_t     regs_y,
    input  addr_t     stack_ptr,
    input  addr_t     idx_addr,  // base address from the index unit
    input  logic      idx_adv,   // step one byte past idx_addr
    input  addr_t     vec_addr,  // vector chosen by the interrupt priority
    output addr_t     eff_addr
);

    addr_t push_addr;  // stack grows down, pre-decrement by access size
    addr_t index_addr;

    // push decrement: one for a byte, two for a word
    assign push_addr  = stack_ptr - (req_wide ? 16'd2 : 16'd1);
    assign index_addr = idx_addr + {15'd0, idx_adv};

    always_comb begin
        case (req_src)
            src_fetch: begin
                eff_addr = pc;          // opcode byte
            end
            src_operand: begin
                eff_addr = pc;          // operand byte or word
            end
            src_x: begin
                eff_addr = regs_x;
            end
            src_y: begin
                eff_addr = regs_y;
            end
            src_push: begin
                eff_addr = push_addr;
            end
            src_pull: begin
                eff_addr = stack_ptr;   // pull reads at the current top
            end
            src_index: begin
                eff_addr = index_addr;
            end
            src_vector: begin
                eff_addr = vec_addr;
            end
            default: begin
                eff_addr = pc;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/mem_byte_seq.sv
// request/response sequencer, splits each access into one or two byte cycles on the 8-bit ram
`timescale 1ns/10ps
`default_nettype none

module mem_byte_seq import memctrl_pkg::*; (
    input  logic      clk,
    input  logic      rst,

    // request channel
    input  logic      req_valid,
    output logic      req_ready,
    input  addr_src_t req_src,
    input  logic      req_wide,
    input  logic      req_write,
    input  word_t     req_wdata,
    input  addr_t     eff_addr,   // from the address selector, stable with req_valid

    // response channel, reads only
    output logic      rsp_valid,
    input  logic      rsp_ready,
    output word_t     rsp_data,
    output logic      rsp_is_op,  // byte fetched as an opcode

    // ram byte port
    output addr_t     ram_addr,
    output logic      ram_we,
    output byte_t     ram_wdata,
    input  byte_t     ram_rdata   // registered, one cycle after the address
);

    seq_state_t state_q;
    seq_state_t state_d;

    logic  wide_q;     // two byte cycles
    logic  write_q;
    logic  is_op_q;
    addr_t addr_q;     // latched low byte address
    word_t wdata_q;
    word_t data_q;     // assembled read result

    logic  accept;
    logic  is_vec;

    assign is_vec = (req_src == src_vector);
    assign accept = req_valid && req_ready;

    // next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle: begin
                if (accept) state_d = st_lo;
            end
            st_lo: begin
                if (wide_q)       state_d = st_hi;
                else if (write_q) state_d = st_idle; // byte write done in one cycle
                else              state_d = st_wait;
            end
            st_hi: begin
                state_d = write_q ? st_idle : st_wait;
            end
            st_wait: begin
                state_d = st_resp;   // last ram byte is on ram_rdata now
            end
            st_resp: begin
                if (rsp_ready) state_d = st_idle;
            end
            default: begin
                state_d = st_idle;
            end
        endcase
    end

    // control state
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= st_idle;
            wide_q  <= 1'b0;
            write_q <= 1'b0;
            is_op_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (accept) begin
                wide_q  <= req_wide || is_vec;    // vectors are always words
                write_q <= req_write && !is_vec;  // and always reads
                is_op_q <= (req_src == src_fetch) && !req_wide;
            end
        end
    end

    // payload, latched on accept and filled from the ram
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q  <= eff_addr;
            wdata_q <= req_wdata;
        end
        if (state_q == st_hi) begin
            data_q[7:0] <= ram_rdata;          // low byte of a word read
        end
        if (state_q == st_wait) begin
            if (wide_q) begin
                data_q[15:8] <= ram_rdata;     // high byte closes the word
            end else begin
                data_q[7:0]  <= ram_rdata;
                data_q[15:8] <= 8'h00;         // byte reads are zero extended
            end
        end
    end

    // ram port, high byte sits at address plus one
    assign ram_addr  = (state_q == st_hi) ? addr_q + 16'd1 : addr_q;
    assign ram_we    = write_q && ((state_q == st_lo) || (state_q == st_hi));
    assign ram_wdata = (state_q == st_hi) ? wdata_q[15:8] : wdata_q[7:0];

    // handshakes, response holds in st_resp until taken
    assign req_ready = (state_q == st_idle);
    assign rsp_valid = (state_q == st_resp);
    assign rsp_data  = data_q;
    assign rsp_is_op = is_op_q;

endmodule

`default_nettype wire

//--- hdl/mem_subsys_top.sv
// memory subsystem top, ties address mux, vector registers, byte sequencer and ram together
`timescale 1ns/10ps
`default_nettype none

module mem_subsys_top import memctrl_pkg::*; (
    input  logic      clk,
    input  logic      rst,

    // request from the control unit
    input  logic      req_valid,
    output logic      req_ready,
    input  addr_src_t req_src,
    input  logic      req_wide,
    input  logic      req_write,
    input  word_t     req_wdata,
    input  intvec_t   req_intvec,

    // cpu registers, held while req_valid is high
    input  addr_t     pc,
    input  addr_t     regs_x,
    input  addr_t     regs_y,
    input  addr_t     stack_ptr,
    input  addr_t     idx_addr,
    input  logic      idx_adv,

    // vector register programming
    input  logic      cfg_we,
    input  logic      [1:0] cfg_sel,
    input  addr_t     cfg_wdata,

    // read response
    output logic      rsp_valid,
    input  logic      rsp_ready,
    output word_t     rsp_data,
    output logic      rsp_is_op
);

    addr_t vec_addr;   // priority-picked vector
    addr_t eff_addr;   // address for the pending request
    addr_t ram_addr;
    logic  ram_we;
    byte_t ram_wdata;
    byte_t ram_rdata;

    int_vector_regs u_vec (
        .clk        (clk),
        .rst        (rst),
        .cfg_we     (cfg_we),
        .cfg_sel    (cfg_sel),
        .cfg_wdata  (cfg_wdata),
        .req_intvec (req_intvec),
        .vec_addr   (vec_addr)
    );

    mem_addr_sel u_asel (
        .req_src    (req_src),
        .req_wide   (req_wide),
        .pc         (pc),
        .regs_x     (regs_x),
        .regs_y     (regs_y),
        .stack_ptr  (stack_ptr),
        .idx_addr   (idx_addr),
        .idx_adv    (idx_adv),
        .vec_addr   (vec_addr),
        .eff_addr   (eff_addr)
    );

    mem_byte_seq u_seq (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_src    (req_src),
        .req_wide   (req_wide),
        .req_write  (req_write),
        .req_wdata  (req_wdata),
        .eff_addr   (eff_addr),
        .rsp_valid  (rsp_valid),
        .rsp_ready  (rsp_ready),
        .rsp_data   (rsp_data),
        .rsp_is_op  (rsp_is_op),
        .ram_addr   (ram_addr),
        .ram_we     (ram_we),
        .ram_wdata  (ram_wdata),
        .ram_rdata  (ram_rdata)
    );

    sys_ram u_ram (
        .clk        (clk),
        .addr       (ram_addr),
        .we         (ram_we),
        .wdata      (ram_wdata),
        .rdata      (ram_rdata)
    );

endmodule

`default_nettype wire

//--- hdl/memctrl_pkg.sv
// shared types, address source and sequencer encodings, and vector reset values for the memory side
`default_nettype none

package memctrl_pkg;

    // widths that carry a meaning
    typedef logic [15:0] addr_t;   // cpu address
    typedef logic [7:0]  byte_t;   // ram and bus byte
    typedef logic [15:0] word_t;   // access data, low byte at the lower address
    typedef logic [3:0]  intvec_t; // bit 0 irq, 1 firq, 2 nmi, 3 rst

    // ram address width, full 64 KiB
    localparam int ram_aw = 16;

    // vector register reset values, top of memory
    localparam addr_t vec_irq_rst  = 16'hFFF8;
    localparam addr_t vec_firq_rst = 16'hFFF6;
    localparam addr_t vec_nmi_rst  = 16'hFFFC;
    localparam addr_t vec_rst_rst  = 16'hFFFE;

    // where the effective address of a request comes from
    typedef enum logic [2:0] {
        src_fetch   = 3'd0, // opcode at pc
        src_operand = 3'd1, // operand at pc
        src_x       = 3'd2,
        src_y       = 3'd3,
        src_push    = 3'd4, // pre-decremented stack pointer
        src_pull    = 3'd5, // stack pointer as is
        src_index   = 3'd6, // indexed address plus advance
        src_vector  = 3'd7  // interrupt vector, always a word read
    } addr_src_t;

    // byte sequencer states
    typedef enum logic [2:0] {
        st_idle = 3'd0, // ready for a request
        st_lo   = 3'd1, // low byte cycle
        st_hi   = 3'd2, // high byte cycle, words only
        st_wait = 3'd3, // last registered ram byte arrives
        st_resp = 3'd4  // read result on offer
    } seq_state_t;

endpackage

`default_nettype wire

//--- hdl/sys_ram.sv
// 64 KiB byte-wide system ram, single port, synchronous write and registered read
`timescale 1ns/10ps
`default_nettype none

module sys_ram import memctrl_pkg::*; (
    input  logic  clk,
    input  addr_t addr,
    input  logic  we,
    input  byte_t wdata,
    output byte_t rdata   // valid the cycle after addr
);

    byte_t mem [2**ram_aw]; // contents undefined until written

    // write on the edge
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    // read register, old data when reading a byte under write
    always_ff @(posedge clk) begin
        rdata <= mem[addr];
    end

endmodule

`default_nettype wire

//--- tb/tb_mem_model.svh
// testbench model of the memory side, included in the testbench top for shadow state and checks
`ifndef TB_MEM_MODEL_SVH
`define TB_MEM_MODEL_SVH

byte_t shadow_mem [65536];  // every byte the testbench has written
addr_t shadow_vec [4];      // expected vector registers, intvec bit order
word_t exp_data_q [$];      // read results still owed by the DUT, in order
logic  exp_op_q [$];

// rst over nmi over firq over irq, nothing pending falls back to rst
function automatic addr_t vector_for(intvec_t iv);
    if (iv[3] || iv == 4'b0000) return shadow_vec[3];
    if (iv[2]) return shadow_vec[2];
    if (iv[1]) return shadow_vec[1];
    return shadow_vec[0];
endfunction

// effective address from the register values handed to the request
function automatic addr_t expected_addr(addr_src_t src, logic wide, intvec_t iv);
    case (src)
        src_x:      return cur_x;
        src_y:      return cur_y;
        src_push:   return wide ? cur_sp - 16'd2 : cur_sp - 16'd1; // pre-decrement
        src_pull:   return cur_sp;
        src_index:  return cur_idx + (cur_adv ? 16'd1 : 16'd0);
        src_vector: return vector_for(iv);
        default:    return cur_pc;                                 // fetch, operand
    endcase
endfunction

// little endian, byte reads come back zero extended
function automatic word_t expected_read(addr_t a, logic wide);
    addr_t a_hi;
    a_hi = a + 16'd1;
    if (wide) return {shadow_mem[a_hi], shadow_mem[a]};
    return {8'h00, shadow_mem[a]};
endfunction

function automatic logic opcode_flag(addr_src_t src, logic wide);
    return (src == src_fetch) && !wide;  // only a byte opcode fetch
endfunction

function automatic void store_shadow(addr_t a, logic wide, word_t d);
    addr_t a_hi;
    a_hi = a + 16'd1;
    shadow_mem[a] = d[7:0];
    if (wide) shadow_mem[a_hi] = d[15:8];
endfunction

task automatic check_word(string name, word_t expected, word_t actual);
    if (actual !== expected) begin
        $display("[FAIL] t=%0t %s expected %h actual %h", $time, name, expected, actual);
        stop_with_failure("data mismatch on the response channel");
    end
endtask

task automatic expect_flag(string name, logic expected, logic actual);
    if (actual !== expected) begin
        $display("[FAIL] t=%0t %s expected %b actual %b", $time, name, expected, actual);
        stop_with_failure("control flag mismatch");
    end
endtask

`endif

//--- tb/tb_mem_subsys.sv
// testbench for mem_subsys_top that checks directed and random accesses against a shadow memory
`timescale 1ns/10ps
`default_nettype none

module tb_mem_subsys import memctrl_pkg::*; ();

    logic       clk;
    logic       rst;
    logic       req_valid;
    logic       req_ready;
    addr_src_t  req_src;
    logic       req_wide;
    logic       req_write;
    word_t      req_wdata;
    intvec_t    req_intvec;
    addr_t      pc;
    addr_t      regs_x;
    addr_t      regs_y;
    addr_t      stack_ptr;
    addr_t      idx_addr;
    logic       idx_adv;
    logic       cfg_we;
    logic [1:0] cfg_sel;
    addr_t      cfg_wdata;
    logic       rsp_valid;
    logic       rsp_ready;
    word_t      rsp_data;
    logic       rsp_is_op;

    addr_t cur_pc;         // register values for the next request
    addr_t cur_x;
    addr_t cur_y;
    addr_t cur_sp;
    addr_t cur_idx;
    logic  cur_adv;
    logic  bp_on = 1'b0;   // random rsp_ready drops

    task automatic stop_with_failure(string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

`include "tb_mem_model.svh"

    mem_subsys_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    // all sources land on a and index reaches it through the advance bit
    task automatic aim_regs(addr_t a);
        cur_pc  = a;
        cur_x   = a;
        cur_y   = a;
        cur_sp  = a;
        cur_idx = a - 16'd1;
        cur_adv = 1'b1;
    endtask

    task automatic issue_access(addr_src_t src, logic wide, logic write, word_t wdata,
                                intvec_t iv);
        addr_t ea;
        logic  w_eff;
        int    n;
        ea    = expected_addr(src, wide, iv);
        w_eff = wide || (src == src_vector);  // vectors always move a word
        @(posedge clk);
        req_valid  <= 1'b1;
        req_src    <= src;
        req_wide   <= wide;
        req_write  <= write;
        req_wdata  <= wdata;
        req_intvec <= iv;
        pc         <= cur_pc;
        regs_x     <= cur_x;
        regs_y     <= cur_y;
        stack_ptr  <= cur_sp;
        idx_addr   <= cur_idx;
        idx_adv    <= cur_adv;
        n = 0;
        @(negedge clk);
        while (!req_ready) begin
            n++;
            if (n > 50) stop_with_failure("timeout, req_ready stayed low for 50 cycles");
            @(negedge clk);
        end
        @(posedge clk);            // accept edge
        req_valid <= 1'b0;
        if (write && src != src_vector) begin
            store_shadow(ea, w_eff, wdata);
        end else begin
            exp_data_q.push_back(expected_read(ea, w_eff));
            exp_op_q.push_back(opcode_flag(src, wide));
        end
    endtask

    task automatic program_vector(logic [1:0] sel, addr_t target);
        @(posedge clk);
        cfg_we    <= 1'b1;
        cfg_sel   <= sel;
        cfg_wdata <= target;
        @(posedge clk);            // write lands on this edge
        cfg_we    <= 1'b0;
        shadow_vec[sel] = target;
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        while (exp_data_q.size() != 0) begin
            @(negedge clk);
            n++;
            if (n > 50) stop_with_failure("timeout, rsp_valid never came for an open read");
        end
    endtask

    // back-pressure drops rsp_ready for 1 to 5 cycles and then raises it for at least one
    initial begin : ready_driver
        int hold;
        rsp_ready = 1'b0;
        forever begin
            @(posedge clk);
            if (bp_on && ($urandom % 4) == 0) begin
                hold = 1 + int'($urandom % 5);
                rsp_ready <= 1'b0;
                repeat (hold) @(posedge clk);
            end
            rsp_ready <= 1'b1;
        end
    end

    // samples at negedge and a transfer happens on the following rising edge
    initial begin : rsp_checker
        word_t held_data;
        logic  held_op;
        logic  held;
        word_t want;
        logic  want_op;
        held = 1'b0;
        forever begin
            @(negedge clk);
            if (!rsp_valid && held) stop_with_failure("rsp_valid dropped before rsp_ready");
            if (rsp_valid) begin
                expect_flag("req_ready", 1'b0, req_ready);   // no request while a read waits
                if (held) begin
                    check_word("rsp_data held", held_data, rsp_data);
                    expect_flag("rsp_is_op held", held_op, rsp_is_op);
                end
                held_data = rsp_data;
                held_op   = rsp_is_op;
                held      = !rsp_ready;
                if (rsp_ready) begin
                    if (exp_data_q.size() == 0) stop_with_failure("response with no open read");
                    want    = exp_data_q.pop_front();
                    want_op = exp_op_q.pop_front();
                    check_word("rsp_data", want, rsp_data);
                    expect_flag("rsp_is_op", want_op, rsp_is_op);
                end
            end
        end
    end

    initial begin : stimulus
        addr_src_t  srcs [4];
        addr_src_t  src;
        logic [2:0] pick;
        addr_t      a;
        addr_t      win;
        srcs = '{src_x, src_y, src_pull, src_index};
        win  = 16'h1000;
        void'($urandom(32'h75b17957));
        rst        = 1'b1;
        req_valid  = 1'b0;
        req_src    = src_fetch;
        req_wide   = 1'b0;
        req_write  = 1'b0;
        req_wdata  = '0;
        req_intvec = '0;
        pc         = '0;
        regs_x     = '0;
        regs_y     = '0;
        stack_ptr  = '0;
        idx_addr   = '0;
        idx_adv    = 1'b0;
        cfg_we     = 1'b0;
        cfg_sel    = 2'd0;
        cfg_wdata  = '0;
        shadow_vec[0] = vec_irq_rst;
        shadow_vec[1] = vec_firq_rst;
        shadow_vec[2] = vec_nmi_rst;
        shadow_vec[3] = vec_rst_rst;
        aim_regs(16'h0000);
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        expect_flag("req_ready", 1'b1, req_ready);
        expect_flag("rsp_valid", 1'b0, rsp_valid);

        // byte write then byte read through each plain source
        for (int i = 0; i < 4; i++) begin
            aim_regs(16'h0100 + 16'(i * 16));
            issue_access(srcs[i], 1'b0, 1'b1, 16'h00a0 + 16'(i), 4'b0000);
            issue_access(srcs[i], 1'b0, 1'b0, '0, 4'b0000);
        end

        // word round trip and then its halves as bytes
        aim_regs(16'h0200);
        issue_access(src_y, 1'b1, 1'b1, 16'hbeef, 4'b0000);
        issue_access(src_y, 1'b1, 1'b0, '0, 4'b0000);
        issue_access(src_x, 1'b0, 1'b0, '0, 4'b0000);
        cur_x = 16'h0201;
        issue_access(src_x, 1'b0, 1'b0, '0, 4'b0000);

        // pushes land below the stack pointer
        aim_regs(16'h0300);
        issue_access(src_push, 1'b0, 1'b1, 16'h005c, 4'b0000);
        cur_x = 16'h02ff;
        issue_access(src_x, 1'b0, 1'b0, '0, 4'b0000);
        issue_access(src_push, 1'b1, 1'b1, 16'h1234, 4'b0000);
        cur_x  = 16'h02fe;
        cur_pc = 16'h02fe;
        issue_access(src_x, 1'b1, 1'b0, '0, 4'b0000);
        issue_access(src_fetch, 1'b0, 1'b0, '0, 4'b0000);    // opcode flag high
        issue_access(src_operand, 1'b0, 1'b0, '0, 4'b0000);  // and low

        // vector requests keep req_wide low and still read a word
        aim_regs(16'hfff8);
        issue_access(src_x, 1'b1, 1'b1, 16'h8123, 4'b0000);
        cur_x = 16'hfffc;
        issue_access(src_x, 1'b1, 1'b1, 16'h9456, 4'b0000);
        issue_access(src_vector, 1'b0, 1'b0, '0, 4'b0001);
        issue_access(src_vector, 1'b0, 1'b0, '0, 4'b0101);   // nmi beats irq
        program_vector(2'd0, 16'h0400);
        cur_x = 16'h0400;
        issue_access(src_x, 1'b1, 1'b1, 16'hc0de, 4'b0000);
        issue_access(src_vector, 1'b0, 1'b0, '0, 4'b0001);

        // fill a window so random reads never hit unwritten ram
        for (int k = 0; k <= 64; k++) begin
            a     = win + 16'(k);
            cur_x = a;
            issue_access(src_x, 1'b0, 1'b1, {8'h00, a[15:8] ^ a[7:0] ^ 8'h5a}, 4'b0000);
        end

        // random mix under back-pressure with vectors left to the directed part
        bp_on = 1'b1;
        for (int i = 0; i < 300; i++) begin
            pick    = 3'($urandom % 7);
            src     = addr_src_t'(pick);
            cur_pc  = win + 16'($urandom % 63);
            cur_x   = win + 16'($urandom % 63);
            cur_y   = win + 16'($urandom % 63);
            cur_sp  = win + 16'd2 + 16'($urandom % 61);  // room for a word push
            cur_idx = win + 16'd1 + 16'($urandom % 62);
            cur_adv = 1'($urandom);
            issue_access(src, 1'($urandom), ($urandom % 3) == 0, 16'($urandom), 4'b0000);
        end

        wait_drained();
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire
